/* logic/cachePkg.sv */
package cachePkg;

  // byte address from the load/store unit
  typedef logic [31:0] addr_t;

  // one 64-bit data word and its byte enables
  typedef logic [63:0] word_t;
  typedef logic [7:0]  mask_t;

  // address split: tag 31..11, index 10..5, word 4..3, byte 2..0
  typedef logic [20:0] tag_t;
  typedef logic [5:0]  index_t;
  typedef logic [1:0]  wordSel_t;

  // sets per way
  localparam int NUM_SETS = 64;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    // dirty victim goes out first
    WRITEBACK,
    REFILL_REQ,
    // burst beats arriving
    REFILL,
    INSTALL
  } ctrlState_e;

endpackage

/* logic/memBusPkg.sv */
package memBusPkg;

  // beats in one burst, one beat per word
  localparam int BEATS_PER_LINE = 4;

  // single beat on the read channel
  typedef logic [63:0] beat_t;

  // full line, beat 0 in the low bits
  typedef logic [BEATS_PER_LINE*64-1:0] line_t;

  // counts beats within a burst
  typedef logic [1:0] beatCnt_t;

endpackage

/* logic/refillBuffer.sv */
`timescale 1ns/1ps

module refillBuffer import memBusPkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  refilling_i,
  input  logic  beat_i,
  input  beat_t beatData_i,
  output line_t line_o
);

  beatCnt_t beatCnt;
  beat_t    beats [BEATS_PER_LINE];

  // count restarts whenever no refill is running
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (!refilling_i) begin
      beatCnt <= '0;
    end else if (beat_i) begin
      beatCnt <= beatCnt + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (refilling_i && beat_i) begin
      beats[beatCnt] <= beatData_i;
    end
  end

  // first beat lands in the low word
  always_comb begin
    for (int i = 0; i < BEATS_PER_LINE; i++) begin
      line_o[i*64 +: 64] = beats[i];
    end
  end

endmodule

/* logic/dataStore.sv */
`timescale 1ns/1ps

module dataStore import cachePkg::*; import memBusPkg::*; (
  input  logic     clk,
  input  index_t   index_i,
  input  wordSel_t wordSel_i,
  input  logic     hitWay_i,
  input  logic     victimWay_i,
  input  logic     storeHit_i,
  input  logic     install_i,
  input  word_t    storeData_i,
  input  mask_t    storeMask_i,
  input  line_t    refillLine_i,
  output word_t    rdWord_o,
  output line_t    victimLine_o
);

  line_t lines0 [NUM_SETS];
  line_t lines1 [NUM_SETS];
  line_t hitLine;
  word_t mergedWord;

  assign hitLine      = hitWay_i ? lines1[index_i] : lines0[index_i];
  assign victimLine_o = victimWay_i ? lines1[index_i] : lines0[index_i];

  // selected word of the hitting way
  assign rdWord_o = hitLine[{wordSel_i, 6'b0} +: 64];

  // store bytes merged over the current word
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      mergedWord[b*8 +: 8] = storeMask_i[b] ? storeData_i[b*8 +: 8] : rdWord_o[b*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (install_i) begin
      if (victimWay_i) begin
        lines1[index_i] <= refillLine_i;
      end else begin
        lines0[index_i] <= refillLine_i;
      end
    end else if (storeHit_i) begin
      if (hitWay_i) begin
        lines1[index_i][{wordSel_i, 6'b0} +: 64] <= mergedWord;
      end else begin
        lines0[index_i][{wordSel_i, 6'b0} +: 64] <= mergedWord;
      end
    end
  end

endmodule

/* logic/tagStore.sv */
`timescale 1ns/1ps

module tagStore import cachePkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  index_t index_i,
  input  tag_t   tag_i,
  input  logic   victimWay_i,
  input  logic   install_i,
  input  logic   storeHit_i,
  output logic   hit_o,
  output logic   hitWay_o,
  output logic   victimDirty_o,
  output tag_t   victimTag_o
);

  tag_t                tags0 [NUM_SETS];
  tag_t                tags1 [NUM_SETS];
  logic [NUM_SETS-1:0] valid0;
  logic [NUM_SETS-1:0] valid1;
  logic [NUM_SETS-1:0] dirty0;
  logic [NUM_SETS-1:0] dirty1;
  logic                hit0;
  logic                hit1;

  // both ways compared in parallel
  assign hit0     = valid0[index_i] && (tags0[index_i] == tag_i);
  assign hit1     = valid1[index_i] && (tags1[index_i] == tag_i);
  assign hit_o    = hit0 || hit1;
  assign hitWay_o = hit1;

  // only a valid dirty line needs writing back
  assign victimDirty_o = victimWay_i ? (valid1[index_i] && dirty1[index_i])
                                     : (valid0[index_i] && dirty0[index_i]);
  assign victimTag_o   = victimWay_i ? tags1[index_i] : tags0[index_i];

  always_ff @(posedge clk) begin
    if (install_i) begin
      if (victimWay_i) begin
        tags1[index_i] <= tag_i;
      end else begin
        tags0[index_i] <= tag_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid0 <= '0;
      valid1 <= '0;
      dirty0 <= '0;
      dirty1 <= '0;
    end else if (install_i) begin
      // fresh line from memory is clean
      if (victimWay_i) begin
        valid1[index_i] <= 1'b1;
        dirty1[index_i] <= 1'b0;
      end else begin
        valid0[index_i] <= 1'b1;
        dirty0[index_i] <= 1'b0;
      end
    end else if (storeHit_i) begin
      if (hitWay_o) begin
        dirty1[index_i] <= 1'b1;
      end else begin
        dirty0[index_i] <= 1'b1;
      end
    end
  end

endmodule

/* logic/dcacheCtrl.sv */
`timescale 1ns/1ps

module dcacheCtrl import cachePkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_i,
  input  logic     we_i,
  input  addr_t    addr_i,
  input  word_t    wdata_i,
  input  mask_t    wmask_i,
  input  logic     hit_i,
  input  logic     victimDirty_i,
  input  tag_t     victimTag_i,
  input  logic     memRdReady_i,
  input  logic     memWrReady_i,
  input  logic     memRdLast_i,
  output logic     ready_o,
  output logic     done_o,
  output index_t   index_o,
  output tag_t     tag_o,
  output wordSel_t wordSel_o,
  output word_t    storeData_o,
  output mask_t    storeMask_o,
  output logic     lookup_o,
  output logic     storeHit_o,
  output logic     install_o,
  output logic     refilling_o,
  output logic     victimWay_o,
  output logic     memRdValid_o,
  output logic     memWrValid_o,
  output addr_t    memRdAddr_o,
  output addr_t    memWrAddr_o
);

  ctrlState_e state;
  ctrlState_e nextState;
  logic       accept;
  logic       lookupMiss;
  logic       weQ;
  tag_t       tagQ;
  index_t     indexQ;
  wordSel_t   wordSelQ;
  word_t      wdataQ;
  mask_t      wmaskQ;
  logic       toggle;
  logic       victimWayQ;

  // a new request can enter while the previous one hits
  assign ready_o    = (state == IDLE) || ((state == LOOKUP) && hit_i);
  assign accept     = req_i && ready_o;
  assign lookupMiss = (state == LOOKUP) && !hit_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (accept) begin
          nextState = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit_i) begin
          nextState = req_i ? LOOKUP : IDLE;
        end else if (victimDirty_i) begin
          nextState = WRITEBACK;
        end else begin
          nextState = REFILL_REQ;
        end
      end
      WRITEBACK: begin
        if (memWrReady_i) begin
          nextState = REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        if (memRdReady_i) begin
          nextState = REFILL;
        end
      end
      REFILL: begin
        if (memRdLast_i) begin
          nextState = INSTALL;
        end
      end
      // line written this cycle, retry the lookup
      INSTALL: nextState = LOOKUP;
      default: nextState = IDLE;
    endcase
  end

  // request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      tagQ     <= addr_i[31:11];
      indexQ   <= addr_i[10:5];
      wordSelQ <= addr_i[4:3];
      wdataQ   <= wdata_i;
      wmaskQ   <= wmask_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weQ <= 1'b0;
    end else if (accept) begin
      weQ <= we_i;
    end
  end

  // toggle picks the victim, the chosen way stays fixed until install
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      toggle     <= 1'b0;
      victimWayQ <= 1'b0;
    end else if (lookupMiss) begin
      toggle     <= ~toggle;
      victimWayQ <= toggle;
    end
  end

  assign victimWay_o = (state == LOOKUP) ? toggle : victimWayQ;

  assign index_o     = indexQ;
  assign tag_o       = tagQ;
  assign wordSel_o   = wordSelQ;
  assign storeData_o = wdataQ;
  assign storeMask_o = wmaskQ;

  assign lookup_o    = (state == LOOKUP);
  assign done_o      = lookup_o && hit_i;
  assign storeHit_o  = done_o && weQ;
  assign install_o   = (state == INSTALL);
  assign refilling_o = (state == REFILL);

  // memory requests are line aligned
  assign memWrValid_o = (state == WRITEBACK);
  assign memWrAddr_o  = {victimTag_i, indexQ, 5'b0};
  assign memRdValid_o = (state == REFILL_REQ);
  assign memRdAddr_o  = {tagQ, indexQ, 5'b0};

endmodule

/* logic/dcacheTop.sv */
`timescale 1ns/1ps

module dcacheTop import cachePkg::*; import memBusPkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // cpu side
  input  logic     req_i,
  input  logic     we_i,
  input  addr_t    addr_i,
  input  word_t    wdata_i,
  input  mask_t    wmask_i,
  output logic     ready_o,
  output logic     done_o,
  output word_t    rdata_o,
  // memory read channel
  output logic     memRdValid_o,
  output addr_t    memRdAddr_o,
  input  logic     memRdReady_i,
  input  logic     memRdBeat_i,
  input  beat_t    memRdData_i,
  input  logic     memRdLast_i,
  // memory write channel
  output logic     memWrValid_o,
  output addr_t    memWrAddr_o,
  output line_t    memWrData_o,
  input  logic     memWrReady_i
);

  logic     hit;
  logic     hitWay;
  logic     victimDirty;
  tag_t     victimTag;
  index_t   index;
  tag_t     tag;
  wordSel_t wordSel;
  word_t    storeData;
  mask_t    storeMask;
  logic     lookup;
  logic     storeHit;
  logic     install;
  logic     refilling;
  logic     victimWay;
  word_t    rdWord;
  line_t    refillLine;

  // read data only carries meaning during a lookup
  assign rdata_o = lookup ? rdWord : '0;

  dcacheCtrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .wmask_i       (wmask_i),
    .hit_i         (hit),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .memRdReady_i  (memRdReady_i),
    .memWrReady_i  (memWrReady_i),
    .memRdLast_i   (memRdLast_i),
    .ready_o       (ready_o),
    .done_o        (done_o),
    .index_o       (index),
    .tag_o         (tag),
    .wordSel_o     (wordSel),
    .storeData_o   (storeData),
    .storeMask_o   (storeMask),
    .lookup_o      (lookup),
    .storeHit_o    (storeHit),
    .install_o     (install),
    .refilling_o   (refilling),
    .victimWay_o   (victimWay),
    .memRdValid_o  (memRdValid_o),
    .memWrValid_o  (memWrValid_o),
    .memRdAddr_o   (memRdAddr_o),
    .memWrAddr_o   (memWrAddr_o)
  );

  tagStore u_tags (
    .clk           (clk),
    .rst_n         (rst_n),
    .index_i       (index),
    .tag_i         (tag),
    .victimWay_i   (victimWay),
    .install_i     (install),
    .storeHit_i    (storeHit),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore u_data (
    .clk          (clk),
    .index_i      (index),
    .wordSel_i    (wordSel),
    .hitWay_i     (hitWay),
    .victimWay_i  (victimWay),
    .storeHit_i   (storeHit),
    .install_i    (install),
    .storeData_i  (storeData),
    .storeMask_i  (storeMask),
    .refillLine_i (refillLine),
    .rdWord_o     (rdWord),
    .victimLine_o (memWrData_o)
  );

  refillBuffer u_refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .refilling_i (refilling),
    .beat_i      (memRdBeat_i),
    .beatData_i  (memRdData_i),
    .line_o      (refillLine)
  );

endmodule

/* verification/memSlave.sv */
`timescale 1ns/1ps

module memSlave import cachePkg::*; import memBusPkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [1:0] delay_i,
  input  logic       memRdValid_i,
  input  addr_t      memRdAddr_i,
  output logic       memRdReady_o,
  output logic       memRdBeat_o,
  output beat_t      memRdData_o,
  output logic       memRdLast_o,
  input  logic       memWrValid_i,
  input  addr_t      memWrAddr_i,
  input  line_t      memWrData_i,
  output logic       memWrReady_o
);

  // sparse backing store, keyed by word address
  word_t mem [addr_t];

  // untouched words read back a pattern of their own address
  function automatic word_t fillWord(input addr_t a);
    return {~a, a ^ 32'hc3a5_5a3c};
  endfunction

  function automatic word_t readWord(input addr_t a);
    return mem.exists(a) ? mem[a] : fillWord(a);
  endfunction

  // one transfer at a time, outputs change on the falling edge
  initial begin
    addr_t base;
    memRdReady_o = 1'b0;
    memRdBeat_o  = 1'b0;
    memRdData_o  = '0;
    memRdLast_o  = 1'b0;
    memWrReady_o = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && memWrValid_i) begin
        repeat (delay_i) @(negedge clk);
        memWrReady_o = 1'b1;
        // line taken on the handshake edge
        @(posedge clk);
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
          mem[memWrAddr_i + addr_t'(i * 8)] = memWrData_i[i*64 +: 64];
        end
        @(negedge clk);
        memWrReady_o = 1'b0;
      end else if (rst_n && memRdValid_i) begin
        base = memRdAddr_i;
        repeat (delay_i) @(negedge clk);
        memRdReady_o = 1'b1;
        @(negedge clk);
        memRdReady_o = 1'b0;
        // burst of four beats, lowest word first
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
          memRdBeat_o = 1'b1;
          memRdData_o = readWord(base + addr_t'(i * 8));
          memRdLast_o = (i == BEATS_PER_LINE - 1);
          @(negedge clk);
        end
        memRdBeat_o = 1'b0;
        memRdLast_o = 1'b0;
      end
    end
  end

endmodule

/* verification/dcacheTb.sv */
`timescale 1ns/1ps

module dcacheTb import cachePkg::*; import memBusPkg::*; ();

  localparam int NUM_RANDOM  = 240;
  localparam int NUM_OPS     = NUM_RANDOM + 20;
  localparam int CYCLE_LIMIT = 60 * NUM_OPS + 100;

  // one accepted request waiting for its done
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t exp;
    int    acceptCycle;
    logic  firstTouch;
  } reqRec_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       req;
  logic       we;
  addr_t      addr;
  word_t      wdata;
  mask_t      wmask;
  logic       ready;
  logic       done;
  word_t      rdata;
  logic       memRdValid;
  addr_t      memRdAddr;
  logic       memRdReady;
  logic       memRdBeat;
  beat_t      memRdData;
  logic       memRdLast;
  logic       memWrValid;
  addr_t      memWrAddr;
  line_t      memWrData;
  logic       memWrReady;
  logic [1:0] memDelay;

  logic [31:0] lfsr        = 32'h50fe9bdc;
  int          cycle       = 0;
  int          wbCount     = 0;
  int          refillCount = 0;
  logic        noWbPhase   = 1'b0;
  logic        refillSeen  = 1'b0;
  reqRec_t     pending [$];
  word_t       shadow [addr_t];
  bit          touched [addr_t];
  // lines stored to since they were last written back
  bit          dirtyLines [addr_t];

  always #2 clk = ~clk;

  dcacheTop uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .wmask_i      (wmask),
    .ready_o      (ready),
    .done_o       (done),
    .rdata_o      (rdata),
    .memRdValid_o (memRdValid),
    .memRdAddr_o  (memRdAddr),
    .memRdReady_i (memRdReady),
    .memRdBeat_i  (memRdBeat),
    .memRdData_i  (memRdData),
    .memRdLast_i  (memRdLast),
    .memWrValid_o (memWrValid),
    .memWrAddr_o  (memWrAddr),
    .memWrData_o  (memWrData),
    .memWrReady_i (memWrReady)
  );

  memSlave memory (
    .clk          (clk),
    .rst_n        (rst_n),
    .delay_i      (memDelay),
    .memRdValid_i (memRdValid),
    .memRdAddr_i  (memRdAddr),
    .memRdReady_o (memRdReady),
    .memRdBeat_o  (memRdBeat),
    .memRdData_o  (memRdData),
    .memRdLast_o  (memRdLast),
    .memWrValid_i (memWrValid),
    .memWrAddr_i  (memWrAddr),
    .memWrData_i  (memWrData),
    .memWrReady_o (memWrReady)
  );

  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return value;
  endfunction

  function automatic word_t patternWord(input addr_t a);
    return {~a, a ^ 32'hc3a5_5a3c};
  endfunction

  function automatic addr_t wordAddr(input addr_t a);
    return {a[31:3], 3'b0};
  endfunction

  function automatic addr_t lineAddr(input addr_t a);
    return {a[31:5], 5'b0};
  endfunction

  // reference model, memory as seen after every accepted store
  function automatic word_t expectedWord(input addr_t a);
    addr_t w;
    w = wordAddr(a);
    return shadow.exists(w) ? shadow[w] : patternWord(w);
  endfunction

  function automatic line_t expectedLine(input addr_t a);
    line_t l;
    for (int i = 0; i < BEATS_PER_LINE; i++) begin
      l[i*64 +: 64] = expectedWord(lineAddr(a) + addr_t'(i * 8));
    end
    return l;
  endfunction

  function automatic tag_t poolTag(input logic [1:0] sel);
    case (sel)
      2'd0:    return 21'h00a31;
      2'd1:    return 21'h01f07;
      2'd2:    return 21'h12c44;
      default: return 21'h0b5e9;
    endcase
  endfunction

  // set 60 stays out of the pool, kept clean for the load-only run
  function automatic index_t poolSet(input logic [1:0] sel);
    case (sel)
      2'd0:    return 6'd5;
      2'd1:    return 6'd12;
      2'd2:    return 6'd33;
      default: return 6'd47;
    endcase
  endfunction

  function automatic addr_t makeAddr(input tag_t t, input index_t s, input wordSel_t w,
                                     input logic [2:0] b);
    return {t, s, w, b};
  endfunction

  task automatic applyStore(input addr_t a, input word_t data, input mask_t mask);
    word_t merged;
    merged = expectedWord(a);
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        merged[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    shadow[wordAddr(a)] = merged;
  endtask

  task automatic failRun(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "dcache testbench stopped on error");
  endtask

  task automatic checkWord(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  task automatic checkAddr(input string name, input addr_t actual, input addr_t expected);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  task automatic checkLine(input string name, input line_t actual, input line_t expected);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  task automatic checkFlag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  // drive on the falling edge, record once the request is taken
  task automatic sendRequest(input logic isStore, input addr_t a, input word_t data,
                             input mask_t mask);
    reqRec_t     rec;
    logic [31:0] r;
    @(negedge clk);
    req   = 1'b1;
    we    = isStore;
    addr  = a;
    wdata = data;
    wmask = mask;
    @(posedge clk);
    while (!ready) begin
      @(posedge clk);
    end
    rec.we          = isStore;
    rec.addr        = a;
    rec.exp         = expectedWord(a);
    rec.acceptCycle = cycle;
    rec.firstTouch  = !touched.exists(lineAddr(a));
    touched[lineAddr(a)] = 1'b1;
    if (isStore) begin
      applyStore(a, data, mask);
      dirtyLines[lineAddr(a)] = 1'b1;
    end
    pending.push_back(rec);
    r = randBits(2);
    memDelay = r[1:0];
  endtask

  task automatic loadWord(input addr_t a);
    sendRequest(1'b0, a, '0, '0);
  endtask

  task automatic storeWord(input addr_t a, input word_t data, input mask_t mask);
    sendRequest(1'b1, a, data, mask);
  endtask

  task automatic drain();
    @(negedge clk);
    req = 1'b0;
    while (pending.size() != 0) begin
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      failRun($sformatf("timeout, test still running after %0d cycles", cycle));
    end
  end

  // compare process, sampled on the rising edge before the DUT updates
  always @(posedge clk) begin
    reqRec_t rec;
    if (rst_n && memRdValid && memRdReady) begin
      if (pending.size() == 0) begin
        failRun("refill requested with no access outstanding");
      end else begin
        checkAddr("memRdAddr_o", memRdAddr, lineAddr(pending[0].addr));
        refillSeen = 1'b1;
        refillCount++;
      end
    end
    if (rst_n && memWrValid) begin
      if (noWbPhase) begin
        failRun("writeback raised during a load-only run");
      end else if (memWrReady) begin
        if (pending.size() == 0) begin
          failRun("writeback raised with no access outstanding");
        end else if (!dirtyLines.exists(memWrAddr) ||
                     memWrAddr[10:5] != pending[0].addr[10:5]) begin
          failRun($sformatf("CHECK FAILED memWrAddr_o: got %h, expected dirty line in set %h",
                            memWrAddr, pending[0].addr[10:5]));
        end else begin
          checkLine("memWrData_o", memWrData, expectedLine(memWrAddr));
          dirtyLines.delete(memWrAddr);
          wbCount++;
        end
      end
    end
    if (rst_n && done) begin
      if (pending.size() == 0) begin
        failRun("done_o raised with no access outstanding");
      end else begin
        rec = pending.pop_front();
        if (!rec.we) begin
          checkWord("rdata_o", rdata, rec.exp);
        end
        if (rec.firstTouch && !refillSeen) begin
          failRun($sformatf("first access to %h finished without a refill", rec.addr));
        end
        // a hit completes one cycle after acceptance
        if (!refillSeen && (cycle - rec.acceptCycle) != 1) begin
          failRun($sformatf("hit on %h took %0d cycles", rec.addr, cycle - rec.acceptCycle));
        end
        refillSeen = 1'b0;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic        isStore;
    addr_t       a;
    word_t       data;
    mask_t       mask;
    int          wbBefore;
    rst_n    = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    wdata    = '0;
    wmask    = '0;
    memDelay = 2'd0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    checkFlag("ready_o", ready, 1'b1);
    checkFlag("done_o", done, 1'b0);
    checkFlag("memRdValid_o", memRdValid, 1'b0);
    checkFlag("memWrValid_o", memWrValid, 1'b0);

    // cold loads, then a masked store and its neighbors
    loadWord(makeAddr(poolTag(2'd0), 6'd5, 2'd0, 3'd0));
    loadWord(makeAddr(poolTag(2'd0), 6'd5, 2'd2, 3'd0));
    loadWord(makeAddr(poolTag(2'd0), 6'd5, 2'd3, 3'd4));
    storeWord(makeAddr(poolTag(2'd0), 6'd5, 2'd0, 3'd2), 64'h1122_3344_5566_7788, 8'h3c);
    loadWord(makeAddr(poolTag(2'd0), 6'd5, 2'd0, 3'd0));
    loadWord(makeAddr(poolTag(2'd0), 6'd5, 2'd1, 3'd0));
    drain();

    // fill both ways of set 5 with dirty lines, then force them out
    wbBefore = wbCount;
    storeWord(makeAddr(poolTag(2'd1), 6'd5, 2'd2, 3'd0), 64'hdead_beef_0bad_f00d, 8'hf0);
    loadWord(makeAddr(poolTag(2'd1), 6'd5, 2'd2, 3'd0));
    loadWord(makeAddr(poolTag(2'd2), 6'd5, 2'd1, 3'd0));
    loadWord(makeAddr(poolTag(2'd0), 6'd5, 2'd0, 3'd0));
    loadWord(makeAddr(poolTag(2'd1), 6'd5, 2'd2, 3'd0));
    drain();
    if (wbCount == wbBefore) begin
      failRun("evicting dirty lines produced no writeback");
    end

    // clean evictions only
    noWbPhase = 1'b1;
    for (int i = 0; i < 9; i++) begin
      loadWord(makeAddr(poolTag(2'(i % 3)), 6'd60, 2'(i % 4), 3'd0));
    end
    drain();
    noWbPhase = 1'b0;

    // random mix, back to back
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = randBits(6);
      a = makeAddr(poolTag(r[1:0]), poolSet(r[3:2]), r[5:4], 3'd0);
      r = randBits(1);
      isStore = r[0];
      r = randBits(32);
      data[63:32] = r;
      r = randBits(32);
      data[31:0] = r;
      r = randBits(8);
      mask = r[7:0];
      if (isStore) begin
        storeWord(a, data, mask);
      end else begin
        loadWord(a);
      end
    end
    drain();

    if (wbCount == 0 || refillCount == 0) begin
      failRun("run ended without both refills and writebacks");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

/* tb.f */
logic/cachePkg.sv
logic/memBusPkg.sv
logic/refillBuffer.sv
logic/dataStore.sv
logic/tagStore.sv
logic/dcacheCtrl.sv
logic/dcacheTop.sv
verification/memSlave.sv
verification/dcacheTb.sv

/* Makefile */
SIM       := verilator
TOP       := dcacheTb
LINT_TOP  := dcacheTop
FILELIST  := tb.f
BUILD_DIR := obj_dir
SIMFLAGS  := --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(SIM) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
